/* ace_keyboard.sv */
`default_nettype none

module ace_keyboard
    import ace_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    input  wire row_t  rows,
    output col_t       columns,
    output logic       kbd_reset,
    output logic       kbd_nmi
);

    logic shift;
    logic clear_all;

    key_event_if  ev_if ();
    key_update_if upd_if ();

    ps2_receiver i_ps2_receiver (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .ev       (ev_if.src)
    );

    // Both consumers see the same event cycle
    modifier_tracker i_modifier_tracker (
        .clk       (clk),
        .rst_n     (rst_n),
        .ev        (ev_if.dst),
        .shift     (shift),
        .clear_all (clear_all),
        .kbd_reset (kbd_reset),
        .kbd_nmi   (kbd_nmi)
    );

    key_translator i_key_translator (
        .clk   (clk),
        .rst_n (rst_n),
        .ev    (ev_if.dst),
        .shift (shift),
        .upd   (upd_if.src)
    );

    key_matrix i_key_matrix (
        .clk       (clk),
        .rst_n     (rst_n),
        .upd       (upd_if.dst),
        .clear_all (clear_all),
        .rows      (rows),
        .columns   (columns)
    );

endmodule

`default_nettype wire

/* ace_pkg.sv */
`default_nettype none

package ace_pkg;

    localparam int MATRIX_ROWS = 8;
    localparam int MATRIX_COLS = 5;

    typedef logic [MATRIX_ROWS-1:0] row_t;  // Active low row select
    typedef logic [MATRIX_COLS-1:0] col_t;  // Active low column sense

    typedef logic [2:0] row_idx_t;
    typedef logic [2:0] col_idx_t;

    typedef struct packed {
        row_idx_t row;
        col_idx_t col;
    } key_pos_t;

    localparam col_t COLS_RELEASED = '1;

    ////////////////////////////////////////////////////////////
    // Matrix layout, columns 0 to 4
    //   row 0  CapsShift SymShift Z X C
    //   row 1  A S D F G
    //   row 2  Q W E R T
    //   row 3  1 2 3 4 5
    //   row 4  0 9 8 7 6
    //   row 5  P O I U Y
    //   row 6  Enter L K J H
    //   row 7  Space M N B V
    ////////////////////////////////////////////////////////////
    localparam key_pos_t KEY_CAPS_SHIFT = '{row: 3'd0, col: 3'd0};
    localparam key_pos_t KEY_SYMBOL_SHIFT = '{row: 3'd0, col: 3'd1};
    localparam key_pos_t KEY_POS_0 = '{row: 3'd4, col: 3'd0};
    localparam key_pos_t KEY_POS_ENTER = '{row: 3'd6, col: 3'd0};
    localparam key_pos_t KEY_POS_SPACE = '{row: 3'd7, col: 3'd0};

    function automatic key_pos_t key_at(input int row, input int col);
        key_pos_t pos;
        pos.row = row_idx_t'(row);
        pos.col = col_idx_t'(col);
        return pos;
    endfunction

endpackage

`default_nettype wire

/* files.f */
ps2_pkg.sv
ace_pkg.sv
key_event_if.sv
key_update_if.sv
ps2_receiver.sv
modifier_tracker.sv
key_translator.sv
key_matrix.sv
ace_keyboard.sv
tb_ps2_host.sv
tb_ace_keyboard.sv

/* key_event_if.sv */
`default_nettype none

// One decoded make or break event, valid for a single clk
interface key_event_if
    import ps2_pkg::*;
();

    logic       valid;
    scan_code_t code;
    logic       released;  // Break code seen
    logic       extended;  // E0 prefix seen

    modport src (
        output valid,
        output code,
        output released,
        output extended
    );

    modport dst (
        input valid,
        input code,
        input released,
        input extended
    );

endinterface

`default_nettype wire

/* key_matrix.sv */
`default_nettype none

module key_matrix
    import ace_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    key_update_if.dst  upd,
    input  wire        clear_all,
    input  wire row_t  rows,
    output col_t       columns
);

    col_t matrix_q [MATRIX_ROWS];  // 0 means pressed

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < MATRIX_ROWS; r++)
                matrix_q[r] <= COLS_RELEASED;
        end
        else if (clear_all)
        begin
            for (int r = 0; r < MATRIX_ROWS; r++)
                matrix_q[r] <= COLS_RELEASED;
        end
        else if (upd.valid)
        begin
            matrix_q[upd.first.row][upd.first.col] <= upd.released;
            if (upd.second_used)
                matrix_q[upd.second.row][upd.second.col] <= upd.released;
        end
    end

    // Host scan, several rows may be low at once
    always_comb
    begin
        columns = COLS_RELEASED;
        for (int r = 0; r < MATRIX_ROWS; r++)
        begin
            if (!rows[r])
                columns = columns & matrix_q[r];
        end
    end

    // Hotkey events never reach the translator output
    a_no_update_on_clear: assert property (@(posedge clk) disable iff (!rst_n)
        !(upd.valid && clear_all));

endmodule

`default_nettype wire

/* key_translator.sv */
`default_nettype none

module key_translator
    import ps2_pkg::*;
    import ace_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    key_event_if.dst   ev,
    input  wire        shift,
    key_update_if.src  upd
);

    key_pos_t pos;
    logic     hit;
    logic     bksp;
    logic     is_digit;
    logic     is_letter;
    logic     add_second;
    key_pos_t second_pos;

    ////////////////////////////////////////////////////////////
    // Scancode lookup
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        pos = '0;
        hit = 1'b1;
        bksp = 1'b0;
        case (ev.code)
            KEY_Z: pos = key_at(0, 2);
            KEY_X: pos = key_at(0, 3);
            KEY_C: pos = key_at(0, 4);
            KEY_A: pos = key_at(1, 0);
            KEY_S: pos = key_at(1, 1);
            KEY_D: pos = key_at(1, 2);
            KEY_F: pos = key_at(1, 3);
            KEY_G: pos = key_at(1, 4);
            KEY_Q: pos = key_at(2, 0);
            KEY_W: pos = key_at(2, 1);
            KEY_E: pos = key_at(2, 2);
            KEY_R: pos = key_at(2, 3);
            KEY_T: pos = key_at(2, 4);
            KEY_1: pos = key_at(3, 0);
            KEY_2: pos = key_at(3, 1);
            KEY_3: pos = key_at(3, 2);
            KEY_4: pos = key_at(3, 3);
            KEY_5: pos = key_at(3, 4);
            KEY_0: pos = KEY_POS_0;
            KEY_9: pos = key_at(4, 1);
            KEY_8: pos = key_at(4, 2);
            KEY_7: pos = key_at(4, 3);
            KEY_6: pos = key_at(4, 4);
            KEY_P: pos = key_at(5, 0);
            KEY_O: pos = key_at(5, 1);
            KEY_I: pos = key_at(5, 2);
            KEY_U: pos = key_at(5, 3);
            KEY_Y: pos = key_at(5, 4);
            KEY_ENTER: pos = KEY_POS_ENTER;
            KEY_L: pos = key_at(6, 1);
            KEY_K: pos = key_at(6, 2);
            KEY_J: pos = key_at(6, 3);
            KEY_H: pos = key_at(6, 4);
            KEY_SPACE: pos = KEY_POS_SPACE;
            KEY_M: pos = key_at(7, 1);
            KEY_N: pos = key_at(7, 2);
            KEY_B: pos = key_at(7, 3);
            KEY_V: pos = key_at(7, 4);
            KEY_BKSP:
            begin
                pos = KEY_POS_0;
                bksp = 1'b1;
            end
            default:
                hit = 1'b0;  // Modifiers and hotkeys land here
        endcase
    end

    // Digits live in rows 3 and 4, the rest of the table is letters
    assign is_digit = !bksp && (pos.row == 3'd3 || pos.row == 3'd4);
    assign is_letter = !bksp && !is_digit && pos != KEY_POS_ENTER && pos != KEY_POS_SPACE;

    always_comb
    begin
        add_second = 1'b1;
        second_pos = KEY_CAPS_SHIFT;
        if (shift && is_digit)
            second_pos = KEY_SYMBOL_SHIFT;
        else if (!bksp && !(shift && is_letter))
            add_second = 1'b0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            upd.valid <= 1'b0;
            upd.released <= 1'b0;
            upd.second_used <= 1'b0;
        end
        else
        begin
            upd.valid <= ev.valid && !ev.extended && hit;
            if (ev.valid)
            begin
                upd.released <= ev.released;
                upd.second_used <= add_second;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ev.valid)
        begin
            upd.first <= pos;
            upd.second <= second_pos;
        end
    end

endmodule

`default_nettype wire

/* key_update_if.sv */
`default_nettype none

interface key_update_if
    import ace_pkg::*;
();

    logic     valid;
    logic     released;
    key_pos_t first;
    logic     second_used;  // Second key also changes
    key_pos_t second;

    modport src (
        output valid,
        output released,
        output first,
        output second_used,
        output second
    );

    modport dst (
        input valid,
        input released,
        input first,
        input second_used,
        input second
    );

endinterface

`default_nettype wire

/* modifier_tracker.sv */
`default_nettype none

module modifier_tracker
    import ps2_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    key_event_if.dst   ev,
    output logic       shift,
    output logic       clear_all,
    output logic       kbd_reset,
    output logic       kbd_nmi
);

    logic shift_q;
    logic ctrl_q;
    logic alt_q;
    logic hotkey;

    assign hotkey = ctrl_q && alt_q;  // Values before the current event
    assign shift = shift_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_q <= 1'b0;
            ctrl_q <= 1'b0;
            alt_q <= 1'b0;
            clear_all <= 1'b0;
            kbd_reset <= 1'b1;
            kbd_nmi <= 1'b1;
        end
        else
        begin
            clear_all <= 1'b0;
            if (ev.valid)
            begin
                case (ev.code)
                    KEY_LSHIFT,
                    KEY_RSHIFT:
                        if (!ev.extended)
                            shift_q <= !ev.released;
                    KEY_CTRL:
                        ctrl_q <= !ev.released;  // Left, or right via E0
                    KEY_LALT:
                        if (!ev.extended)
                            alt_q <= !ev.released;
                    KEY_KP_DOT:
                        if (!ev.extended && hotkey)
                        begin
                            kbd_reset <= ev.released;
                            clear_all <= !ev.released;
                        end
                    KEY_F5:
                        if (!ev.extended && hotkey)
                            kbd_nmi <= ev.released;
                    default:
                        ;
                endcase
            end
        end
    end

    a_clear_after_dot: assert property (@(posedge clk) disable iff (!rst_n)
        clear_all |-> $past(ev.valid && !ev.released && ev.code == KEY_KP_DOT));

endmodule

`default_nettype wire

/* ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

    typedef logic [7:0] scan_code_t;

    // Bits after the start bit: 8 data, parity and stop
    localparam int PS2_FRAME_BITS = 10;
    localparam int PS2_TIMEOUT_CYCLES = 5000;  // Quiet ps2_clk before a frame is dropped

    typedef logic [$clog2(PS2_FRAME_BITS)-1:0] ps2_bit_cnt_t;
    typedef logic [$clog2(PS2_TIMEOUT_CYCLES)-1:0] ps2_timeout_t;

    localparam scan_code_t PREFIX_EXTENDED = 8'hE0;
    localparam scan_code_t PREFIX_BREAK = 8'hF0;

    ////////////////////////////////////////////////////////////
    // Set 2 make codes
    ////////////////////////////////////////////////////////////
    localparam scan_code_t KEY_A = 8'h1C;
    localparam scan_code_t KEY_B = 8'h32;
    localparam scan_code_t KEY_C = 8'h21;
    localparam scan_code_t KEY_D = 8'h23;
    localparam scan_code_t KEY_E = 8'h24;
    localparam scan_code_t KEY_F = 8'h2B;
    localparam scan_code_t KEY_G = 8'h34;
    localparam scan_code_t KEY_H = 8'h33;
    localparam scan_code_t KEY_I = 8'h43;
    localparam scan_code_t KEY_J = 8'h3B;
    localparam scan_code_t KEY_K = 8'h42;
    localparam scan_code_t KEY_L = 8'h4B;
    localparam scan_code_t KEY_M = 8'h3A;
    localparam scan_code_t KEY_N = 8'h31;
    localparam scan_code_t KEY_O = 8'h44;
    localparam scan_code_t KEY_P = 8'h4D;
    localparam scan_code_t KEY_Q = 8'h15;
    localparam scan_code_t KEY_R = 8'h2D;
    localparam scan_code_t KEY_S = 8'h1B;
    localparam scan_code_t KEY_T = 8'h2C;
    localparam scan_code_t KEY_U = 8'h3C;
    localparam scan_code_t KEY_V = 8'h2A;
    localparam scan_code_t KEY_W = 8'h1D;
    localparam scan_code_t KEY_X = 8'h22;
    localparam scan_code_t KEY_Y = 8'h35;
    localparam scan_code_t KEY_Z = 8'h1A;

    localparam scan_code_t KEY_0 = 8'h45;
    localparam scan_code_t KEY_1 = 8'h16;
    localparam scan_code_t KEY_2 = 8'h1E;
    localparam scan_code_t KEY_3 = 8'h26;
    localparam scan_code_t KEY_4 = 8'h25;
    localparam scan_code_t KEY_5 = 8'h2E;
    localparam scan_code_t KEY_6 = 8'h36;
    localparam scan_code_t KEY_7 = 8'h3D;
    localparam scan_code_t KEY_8 = 8'h3E;
    localparam scan_code_t KEY_9 = 8'h46;

    localparam scan_code_t KEY_SPACE = 8'h29;
    localparam scan_code_t KEY_ENTER = 8'h5A;
    localparam scan_code_t KEY_BKSP = 8'h66;
    localparam scan_code_t KEY_LSHIFT = 8'h12;
    localparam scan_code_t KEY_RSHIFT = 8'h59;
    localparam scan_code_t KEY_CTRL = 8'h14;  // Right Ctrl comes with E0
    localparam scan_code_t KEY_LALT = 8'h11;
    localparam scan_code_t KEY_KP_DOT = 8'h71;
    localparam scan_code_t KEY_F5 = 8'h03;

endpackage

`default_nettype wire

/* ps2_receiver.sv */
`default_nettype none

module ps2_receiver
    import ps2_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        ps2_clk,
    input  wire        ps2_data,
    key_event_if.src   ev
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } rx_state_t;

    rx_state_t    state_q;
    ps2_bit_cnt_t bit_cnt_q;
    ps2_timeout_t timeout_q;
    scan_code_t   shift_q;
    logic         parity_ok_q;
    logic         byte_ready_q;
    logic         ext_q;
    logic         brk_q;

    logic clk_meta_q;
    logic clk_sync_q;
    logic clk_prev_q;
    logic data_meta_q;
    logic data_sync_q;
    logic fall;

    ////////////////////////////////////////////////////////////
    // Line synchronisers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_meta_q <= 1'b1;
            clk_sync_q <= 1'b1;
            clk_prev_q <= 1'b1;
            data_meta_q <= 1'b1;
            data_sync_q <= 1'b1;
        end
        else
        begin
            clk_meta_q <= ps2_clk;
            clk_sync_q <= clk_meta_q;
            clk_prev_q <= clk_sync_q;
            data_meta_q <= ps2_data;
            data_sync_q <= data_meta_q;
        end
    end

    assign fall = clk_prev_q && !clk_sync_q;

    ////////////////////////////////////////////////////////////
    // Frame FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ST_IDLE;
            bit_cnt_q <= '0;
            timeout_q <= '0;
            byte_ready_q <= 1'b0;
        end
        else
        begin
            byte_ready_q <= 1'b0;
            if (state_q == ST_IDLE || fall)
                timeout_q <= '0;
            else
                timeout_q <= timeout_q + ps2_timeout_t'(1);

            if (state_q != ST_IDLE && !fall
                && timeout_q == ps2_timeout_t'(PS2_TIMEOUT_CYCLES - 1))
                state_q <= ST_IDLE;  // Drop partial frame
            else if (fall)
            begin
                case (state_q)
                    ST_IDLE:
                        if (!data_sync_q)  // Start bit
                        begin
                            state_q <= ST_DATA;
                            bit_cnt_q <= '0;
                        end
                    ST_DATA:
                    begin
                        bit_cnt_q <= bit_cnt_q + ps2_bit_cnt_t'(1);
                        if (bit_cnt_q == ps2_bit_cnt_t'(PS2_FRAME_BITS - 3))
                            state_q <= ST_PARITY;
                    end
                    ST_PARITY:
                        state_q <= ST_STOP;
                    ST_STOP:
                    begin
                        byte_ready_q <= data_sync_q && parity_ok_q;
                        state_q <= ST_IDLE;
                    end
                    default:
                        state_q <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall && state_q == ST_DATA)
            shift_q <= {data_sync_q, shift_q[7:1]};  // LSB first
        if (fall && state_q == ST_PARITY)
            parity_ok_q <= ^{shift_q, data_sync_q};  // Odd parity
    end

    // Prefix handling and event strobe
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ev.valid <= 1'b0;
            ext_q <= 1'b0;
            brk_q <= 1'b0;
        end
        else
        begin
            ev.valid <= 1'b0;
            if (byte_ready_q)
            begin
                if (shift_q == PREFIX_EXTENDED)
                    ext_q <= 1'b1;
                else if (shift_q == PREFIX_BREAK)
                    brk_q <= 1'b1;
                else
                begin
                    ev.valid <= 1'b1;
                    ext_q <= 1'b0;
                    brk_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_ready_q)
        begin
            ev.code <= shift_q;
            ev.released <= brk_q;
            ev.extended <= ext_q;
        end
    end

    // Bytes are at least a frame apart
    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        ev.valid |=> !ev.valid);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_ace_keyboard -f files.f

output=$(./obj_dir/Vtb_ace_keyboard) || true
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"
then
    exit 0
fi
exit 1

/* tb_ace_keyboard.sv */
`default_nettype none

module tb_ace_keyboard
    import ps2_pkg::*;
    import ace_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HOST_TIMEOUT = 1000;
    localparam int SETTLE_TIMEOUT = 32;

    localparam scan_code_t LETTER_CODES [26] = '{
        KEY_A, KEY_B, KEY_C, KEY_D, KEY_E, KEY_F, KEY_G, KEY_H, KEY_I,
        KEY_J, KEY_K, KEY_L, KEY_M, KEY_N, KEY_O, KEY_P, KEY_Q, KEY_R,
        KEY_S, KEY_T, KEY_U, KEY_V, KEY_W, KEY_X, KEY_Y, KEY_Z};
    localparam scan_code_t DIGIT_CODES [10] = '{
        KEY_0, KEY_1, KEY_2, KEY_3, KEY_4, KEY_5, KEY_6, KEY_7, KEY_8, KEY_9};

    logic       clk = 1'b0;
    logic       rst_n;
    row_t       rows;
    col_t       columns;
    logic       kbd_reset;
    logic       kbd_nmi;
    logic       ps2_clk;
    logic       ps2_data;
    logic       req;
    scan_code_t tx_byte;
    logic       bad_parity;
    logic       done;

    logic [15:0] lfsr = 16'd11;
    col_t        model [MATRIX_ROWS];  // 0 means pressed
    logic        exp_reset;
    logic        exp_nmi;
    logic        shift_held;
    logic        ctrl_held;
    logic        alt_held;

    always #4 clk = ~clk;

    ace_keyboard i_ace_keyboard (
        .clk       (clk),
        .rst_n     (rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .rows      (rows),
        .columns   (columns),
        .kbd_reset (kbd_reset),
        .kbd_nmi   (kbd_nmi)
    );

    tb_ps2_host i_ps2_host (
        .clk        (clk),
        .req        (req),
        .tx_byte    (tx_byte),
        .bad_parity (bad_parity),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .done       (done)
    );

    ////////////////////////////////////////////////////////////
    // Random numbers and reporting
    ////////////////////////////////////////////////////////////
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Galois step
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    task automatic stop_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic string layout_row(input int r);
        case (r)
            0: return "^$ZXC";  // Caps Shift, Symbol Shift
            1: return "ASDFG";
            2: return "QWERT";
            3: return "12345";
            4: return "09876";
            5: return "POIUY";
            6: return "~LKJH";  // Enter first
            default: return "_MNBV";  // Space first
        endcase
    endfunction

    function automatic key_pos_t find_key(input byte ch);
        key_pos_t pos;
        string    line;
        pos = '0;
        for (int r = 0; r < MATRIX_ROWS; r++)
        begin
            line = layout_row(r);
            for (int c = 0; c < MATRIX_COLS; c++)
                if (line[c] == ch)
                    pos = '{row: row_idx_t'(r), col: col_idx_t'(c)};
        end
        return pos;
    endfunction

    function automatic byte code_to_char(input scan_code_t code);
        byte ch;
        ch = 0;
        for (int i = 0; i < 26; i++)
            if (LETTER_CODES[i] == code)
                ch = byte'("A" + i);
        for (int i = 0; i < 10; i++)
            if (DIGIT_CODES[i] == code)
                ch = byte'("0" + i);
        if (code == KEY_SPACE)
            ch = "_";
        if (code == KEY_ENTER)
            ch = "~";
        if (code == KEY_BKSP)
            ch = "<";
        return ch;
    endfunction

    // kind 0 letter, 1 digit, 2 either
    function automatic scan_code_t pick_key(input int kind);
        int k;
        k = (kind == 2) ? random_bits(1) : kind;
        if (k == 0)
            return LETTER_CODES[random_bits(5) % 26];
        return DIGIT_CODES[random_bits(4) % 10];
    endfunction

    task automatic set_key(input key_pos_t pos, input logic value);
        model[pos.row][pos.col] = value;
    endtask

    task automatic model_event(input scan_code_t code, input logic ext, input logic released);
        byte  ch;
        logic hot;
        hot = ctrl_held && alt_held;  // Modifiers before this event
        ch = ext ? 8'd0 : code_to_char(code);
        if (ch == "<")
        begin
            set_key(find_key("0"), released);
            set_key(find_key("^"), released);
        end
        else if (ch != 0)
        begin
            set_key(find_key(ch), released);
            if (shift_held && ch >= "A" && ch <= "Z")
                set_key(find_key("^"), released);
            if (shift_held && ch >= "0" && ch <= "9")
                set_key(find_key("$"), released);
        end
        case (code)
            KEY_LSHIFT,
            KEY_RSHIFT:
                if (!ext)
                    shift_held = !released;
            KEY_CTRL:
                ctrl_held = !released;
            KEY_LALT:
                if (!ext)
                    alt_held = !released;
            KEY_KP_DOT:
                if (!ext && hot)
                begin
                    exp_reset = released;
                    if (!released)
                        for (int r = 0; r < MATRIX_ROWS; r++)
                            model[r] = '1;
                end
            KEY_F5:
                if (!ext && hot)
                    exp_nmi = released;
            default:
                ;
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and checks
    ////////////////////////////////////////////////////////////
    task automatic send_byte(input scan_code_t value, input logic corrupt);
        int cycles;
        tx_byte <= value;
        bad_parity <= corrupt;
        req <= 1'b1;
        @(posedge clk);
        req <= 1'b0;
        cycles = 0;
        while (!done && cycles < HOST_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("PS/2 host did not finish a frame in time");
            stop_with_failure();
        end
    endtask

    task automatic wait_settled();
        col_t expected;
        int   cycles;
        expected = '1;
        for (int r = 0; r < MATRIX_ROWS; r++)
            expected &= model[r];
        rows <= '0;  // All rows at once
        cycles = 0;
        @(posedge clk);
        while ((columns !== expected || kbd_reset !== exp_reset || kbd_nmi !== exp_nmi)
               && cycles < SETTLE_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic scan_and_compare(input string name);
        for (int r = 0; r < MATRIX_ROWS; r++)
        begin
            rows <= row_t'(~(8'd1 << r));
            @(posedge clk);
            check_value($sformatf("%s row %0d", name, r), 32'(model[r]), 32'(columns));
        end
        rows <= '1;
        check_value({name, " kbd_reset"}, 32'(exp_reset), 32'(kbd_reset));
        check_value({name, " kbd_nmi"}, 32'(exp_nmi), 32'(kbd_nmi));
    endtask

    task automatic key_action(input scan_code_t code, input logic ext, input logic released,
                              input string name);
        if (ext)
            send_byte(PREFIX_EXTENDED, 1'b0);
        if (released)
            send_byte(PREFIX_BREAK, 1'b0);
        send_byte(code, 1'b0);
        model_event(code, ext, released);
        wait_settled();
        scan_and_compare(name);
    endtask

    initial
    begin
        scan_code_t code;
        scan_code_t shift_code;
        scan_code_t held [3];
        logic       right_ctrl;

        rst_n = 1'b0;
        rows = '1;
        req = 1'b0;
        tx_byte = '0;
        bad_parity = 1'b0;
        for (int r = 0; r < MATRIX_ROWS; r++)
            model[r] = '1;
        exp_reset = 1'b1;
        exp_nmi = 1'b1;
        shift_held = 1'b0;
        ctrl_held = 1'b0;
        alt_held = 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        wait_settled();
        scan_and_compare("after reset");

        for (int i = 0; i < 12; i++)
        begin
            code = pick_key(2);
            key_action(code, 1'b0, 1'b0, "plain press");
            key_action(code, 1'b0, 1'b1, "plain release");
        end

        shift_code = random_bits(1) ? KEY_RSHIFT : KEY_LSHIFT;
        key_action(shift_code, 1'b0, 1'b0, "shift press");
        for (int i = 0; i < 10; i++)
        begin
            code = pick_key(i % 2);  // Letters and digits in turn
            key_action(code, 1'b0, 1'b0, "shifted press");
            key_action(code, 1'b0, 1'b1, "shifted release");
        end
        key_action(shift_code, 1'b0, 1'b1, "shift release");

        key_action(KEY_SPACE, 1'b0, 1'b0, "space press");
        key_action(KEY_SPACE, 1'b0, 1'b1, "space release");
        key_action(KEY_ENTER, 1'b0, 1'b0, "enter press");
        key_action(KEY_ENTER, 1'b0, 1'b1, "enter release");
        key_action(KEY_BKSP, 1'b0, 1'b0, "backspace press");
        key_action(KEY_BKSP, 1'b0, 1'b1, "backspace release");

        ////////////////////////////////////////////////////////////
        // Hotkeys
        ////////////////////////////////////////////////////////////
        key_action(KEY_F5, 1'b0, 1'b0, "F5 alone press");
        key_action(KEY_F5, 1'b0, 1'b1, "F5 alone release");
        right_ctrl = 1'(random_bits(1));
        key_action(KEY_CTRL, right_ctrl, 1'b0, "nmi ctrl press");
        key_action(KEY_LALT, 1'b0, 1'b0, "nmi alt press");
        key_action(KEY_F5, 1'b0, 1'b0, "nmi F5 press");
        key_action(KEY_F5, 1'b0, 1'b1, "nmi F5 release");
        key_action(KEY_LALT, 1'b0, 1'b1, "nmi alt release");
        key_action(KEY_CTRL, right_ctrl, 1'b1, "nmi ctrl release");

        for (int i = 0; i < 3; i++)
        begin
            held[i] = pick_key(2);
            key_action(held[i], 1'b0, 1'b0, "held key press");
        end
        right_ctrl = 1'(random_bits(1));
        key_action(KEY_CTRL, right_ctrl, 1'b0, "reset ctrl press");
        key_action(KEY_LALT, 1'b0, 1'b0, "reset alt press");
        key_action(KEY_KP_DOT, 1'b0, 1'b0, "reset dot press");
        key_action(KEY_KP_DOT, 1'b0, 1'b1, "reset dot release");
        key_action(KEY_LALT, 1'b0, 1'b1, "reset alt release");
        key_action(KEY_CTRL, right_ctrl, 1'b1, "reset ctrl release");
        for (int i = 0; i < 3; i++)
            key_action(held[i], 1'b0, 1'b1, "held key release");

        code = pick_key(0);
        send_byte(code, 1'b1);  // Frame must be dropped
        wait_settled();
        scan_and_compare("bad parity");
        key_action(code, 1'b0, 1'b0, "after bad parity press");
        key_action(code, 1'b0, 1'b1, "after bad parity release");

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_ps2_host.sv */
`default_nettype none

module tb_ps2_host
    import ps2_pkg::*;
(
    input  wire             clk,
    input  wire             req,
    input  wire scan_code_t tx_byte,
    input  wire             bad_parity,
    output logic            ps2_clk,
    output logic            ps2_data,
    output logic            done
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 20;  // clk cycles per PS/2 clock phase

    task automatic half_period();
        for (int i = 0; i < HALF_PERIOD; i++)
            @(posedge clk);
    endtask

    // Device side, data changes while ps2_clk is high
    task automatic send_bit(input logic value);
        ps2_data <= value;
        half_period();
        ps2_clk <= 1'b0;  // Receiver samples here
        half_period();
        ps2_clk <= 1'b1;
    endtask

    task automatic send_frame(input scan_code_t value, input logic corrupt);
        logic parity;
        parity = ~^value ^ corrupt;  // Odd parity unless corrupted
        send_bit(1'b0);
        for (int i = 0; i < 8; i++)
            send_bit(value[i]);  // LSB first
        send_bit(parity);
        send_bit(1'b1);
        half_period();  // Idle line before the next frame
    endtask

    ////////////////////////////////////////////////////////////
    // Request loop
    ////////////////////////////////////////////////////////////
    initial
    begin
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        done = 1'b0;
        forever
        begin
            @(posedge clk);
            done <= 1'b0;
            if (req)
            begin
                send_frame(tx_byte, bad_parity);
                done <= 1'b1;  // One cycle strobe
            end
        end
    end

endmodule

`default_nettype wire
